// ==== include/ctrl_config.svh ====
`ifndef CTRL_CONFIG_SVH
`define CTRL_CONFIG_SVH

// message and tree size
`define CTRL_MSG_WIDTH 64
`define CTRL_NUM_CHILDREN 4
`define CTRL_STAMP_WIDTH 16

// field positions within one message
`define MSG_DEST_MSB 63
`define MSG_DEST_LSB 56
`define MSG_HEADER_MSB 55
`define MSG_HEADER_LSB 48
`define MSG_STAMP_MSB 31
`define MSG_STAMP_LSB 16
`define MSG_VALUE_MSB 15
`define MSG_VALUE_LSB 0
`define MSG_NODE_MSB 7
`define MSG_NODE_LSB 0

// flag bits
`define MSG_SUMMARY_BIT 31
`define MSG_WAIT_BIT 2
`define MSG_REPORT_ALL_BIT 3

`define LEAF_DEFAULT_WORK 8
`define CTRL_BROADCAST_DEST 8'hff

`endif

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the cluster testbench, the pass line in sim.log decides the result
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f verilog.f \
    --top-module tb_decoder_cluster -o sim_decoder_cluster > build.log 2>&1 &&
    ./obj_dir/sim_decoder_cluster +verilator+error+limit+10 > sim.log 2>&1
grep -qx "Testbench passed" sim.log 2>/dev/null && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== src/child_fanout.sv ====
`timescale 1ns/1ps
`include "ctrl_config.svh"

module child_fanout #(
    parameter int NUM_CHILDREN = `CTRL_NUM_CHILDREN
) (
    // downstream from the root
    input  ctrl_pkg::ctrl_msg_t     data_in,
    input  logic                    valid_in,
    output logic                    ready_in,

    // broadcast to the leaves
    output ctrl_pkg::ctrl_msg_t     leaf_data,
    output logic                    leaf_valid,
    input  logic [NUM_CHILDREN-1:0] leaf_ready,

    // results from the leaves
    input  ctrl_pkg::ctrl_msg_t     result_data [NUM_CHILDREN],
    input  logic [NUM_CHILDREN-1:0] result_valid,
    output logic [NUM_CHILDREN-1:0] result_ready,

    // merged results up to the root
    output ctrl_pkg::ctrl_msg_t     data_out,
    output logic                    valid_out,
    input  logic                    ready_out,

    input  logic [NUM_CHILDREN-1:0] leaf_busy,
    output logic                    router_busy
);

    // every leaf must take the message in the same cycle
    assign ready_in = &leaf_ready;

    // valid only reaches the leaves once all of them are ready,
    // so no leaf can take a message twice
    assign leaf_valid = valid_in && ready_in;
    assign leaf_data  = data_in;

    assign router_busy = |leaf_busy;

    // fixed priority, lowest index first
    always_comb begin
        logic found;
        found        = 1'b0;
        data_out     = result_data[0];
        valid_out    = 1'b0;
        result_ready = '0;
        for (int i = 0; i < NUM_CHILDREN; i++) begin
            if (result_valid[i] && !found) begin
                found           = 1'b1;
                data_out        = result_data[i];
                valid_out       = 1'b1;
                result_ready[i] = ready_out;
            end
        end
    end

endmodule

// ==== src/ctrl_pkg.sv ====
`include "ctrl_config.svh"

package ctrl_pkg;

    // one control message
    typedef logic [`CTRL_MSG_WIDTH-1:0] ctrl_msg_t;

    // destination byte, also used as a node id
    typedef logic [`MSG_DEST_MSB-`MSG_DEST_LSB:0] node_id_t;

    typedef logic [`MSG_HEADER_MSB-`MSG_HEADER_LSB:0] msg_header_t;

    // node timestamp, workload and latency all share this width
    typedef logic [`CTRL_STAMP_WIDTH-1:0] timestamp_t;

    // holds 0 up to NUM_CHILDREN inclusive
    typedef logic [$clog2(`CTRL_NUM_CHILDREN + 1)-1:0] child_count_t;

    // header codes
    localparam msg_header_t HEADER_INITIALIZE_DECODING = 8'd1;
    localparam msg_header_t HEADER_SET_BOUNDARIES = 8'd2;
    localparam msg_header_t HEADER_DECODE_BLOCK = 8'd3;
    localparam msg_header_t HEADER_RESET_CLOCK = 8'd4;
    localparam msg_header_t HEADER_RESULT = 8'd6;

    // root controller stages
    typedef enum logic [0:0] {
        STAGE_IDLE,
        STAGE_WAIT_TILL_NODE_RESULTS
    } root_stage_t;

endpackage

// ==== src/decoder_cluster_top.sv ====
`timescale 1ns/1ps
`include "ctrl_config.svh"

module decoder_cluster_top (
    input  logic                clk,
    input  logic                reset,

    input  ctrl_pkg::ctrl_msg_t data_from_cpu,
    input  logic                valid_from_cpu,
    output logic                ready_from_cpu,

    output ctrl_pkg::ctrl_msg_t data_to_cpu,
    output logic                valid_to_cpu,
    input  logic                ready_to_cpu
);

    localparam int NUM_CHILDREN = `CTRL_NUM_CHILDREN;

    // root to fan-out
    ctrl_pkg::ctrl_msg_t     data_to_fpgas;
    logic                    valid_to_fpgas;
    logic                    ready_to_fpgas;
    ctrl_pkg::ctrl_msg_t     data_from_fpgas;
    logic                    valid_from_fpgas;
    logic                    ready_from_fpgas;
    logic                    router_busy;

    // fan-out to leaves
    ctrl_pkg::ctrl_msg_t     leaf_data;
    logic                    leaf_valid;
    logic [NUM_CHILDREN-1:0] leaf_ready;
    ctrl_pkg::ctrl_msg_t     result_data [NUM_CHILDREN];
    logic [NUM_CHILDREN-1:0] result_valid;
    logic [NUM_CHILDREN-1:0] result_ready;
    logic [NUM_CHILDREN-1:0] leaf_busy;

    root_controller #(
        .NUM_CHILDREN(NUM_CHILDREN)
    ) root_i (
        .clk             (clk),
        .reset           (reset),
        .data_from_cpu   (data_from_cpu),
        .valid_from_cpu  (valid_from_cpu),
        .ready_from_cpu  (ready_from_cpu),
        .data_to_cpu     (data_to_cpu),
        .valid_to_cpu    (valid_to_cpu),
        .ready_to_cpu    (ready_to_cpu),
        .data_to_fpgas   (data_to_fpgas),
        .valid_to_fpgas  (valid_to_fpgas),
        .ready_to_fpgas  (ready_to_fpgas),
        .data_from_fpgas (data_from_fpgas),
        .valid_from_fpgas(valid_from_fpgas),
        .ready_from_fpgas(ready_from_fpgas),
        .router_busy     (router_busy)
    );

    child_fanout #(
        .NUM_CHILDREN(NUM_CHILDREN)
    ) fanout_i (
        .data_in     (data_to_fpgas),
        .valid_in    (valid_to_fpgas),
        .ready_in    (ready_to_fpgas),
        .leaf_data   (leaf_data),
        .leaf_valid  (leaf_valid),
        .leaf_ready  (leaf_ready),
        .result_data (result_data),
        .result_valid(result_valid),
        .result_ready(result_ready),
        .data_out    (data_from_fpgas),
        .valid_out   (valid_from_fpgas),
        .ready_out   (ready_from_fpgas),
        .leaf_busy   (leaf_busy),
        .router_busy (router_busy)
    );

    // node ids start at 1, id 0 is the root
    for (genvar i = 0; i < NUM_CHILDREN; i++) begin : g_leaf
        leaf_node #(
            .NODE_ID(ctrl_pkg::node_id_t'(i + 1))
        ) leaf_i (
            .clk         (clk),
            .reset       (reset),
            .in_data     (leaf_data),
            .in_valid    (leaf_valid),
            .in_ready    (leaf_ready[i]),
            .result_data (result_data[i]),
            .result_valid(result_valid[i]),
            .result_ready(result_ready[i]),
            .busy        (leaf_busy[i])
        );
    end

endmodule

// ==== src/leaf_node.sv ====
`timescale 1ns/1ps
`include "ctrl_config.svh"

module leaf_node #(
    parameter ctrl_pkg::node_id_t NODE_ID = 8'd1
) (
    input  logic                clk,
    input  logic                reset,

    input  ctrl_pkg::ctrl_msg_t in_data,
    input  logic                in_valid,
    output logic                in_ready,

    output ctrl_pkg::ctrl_msg_t result_data,
    output logic                result_valid,
    input  logic                result_ready,

    output logic                busy
);

    localparam ctrl_pkg::timestamp_t DEFAULT_WORK = ctrl_pkg::timestamp_t'(`LEAF_DEFAULT_WORK);

    ctrl_pkg::timestamp_t  stamp;
    ctrl_pkg::timestamp_t  workload;
    ctrl_pkg::timestamp_t  decode_count;
    logic                  wait_q;
    ctrl_pkg::ctrl_msg_t   result_msg;

    ctrl_pkg::node_id_t    in_dest;
    ctrl_pkg::msg_header_t in_header;
    logic                  take;
    logic                  decode_done;

    assign in_dest   = in_data[`MSG_DEST_MSB:`MSG_DEST_LSB];
    assign in_header = in_data[`MSG_HEADER_MSB:`MSG_HEADER_LSB];

    // closed from decode start until the result has been taken
    assign in_ready = !busy && !result_valid;

    assign take = in_valid && in_ready &&
        (in_dest == NODE_ID || in_dest == `CTRL_BROADCAST_DEST);
    assign decode_done = busy && (decode_count == ctrl_pkg::timestamp_t'(1));

    // local clock
    always_ff @(posedge clk) begin
        if (reset) begin
            stamp <= '0;
        end else if (take && in_header == ctrl_pkg::HEADER_RESET_CLOCK) begin
            stamp <= '0;
        end else begin
            stamp <= stamp + 1'b1;
        end
    end

    // boundaries only apply when sent to this node directly
    always_ff @(posedge clk) begin
        if (reset) begin
            workload <= DEFAULT_WORK;
        end else if (take && in_header == ctrl_pkg::HEADER_INITIALIZE_DECODING) begin
            workload <= DEFAULT_WORK;
        end else if (take && in_dest == NODE_ID &&
                     in_header == ctrl_pkg::HEADER_SET_BOUNDARIES) begin
            workload <= in_data[`MSG_VALUE_MSB:`MSG_VALUE_LSB];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy         <= 1'b0;
            wait_q       <= 1'b0;
            decode_count <= '0;
            result_valid <= 1'b0;
        end else begin
            if (take && in_header == ctrl_pkg::HEADER_DECODE_BLOCK) begin
                busy         <= 1'b1;
                wait_q       <= in_data[`MSG_WAIT_BIT];
                // a zero workload still takes one cycle
                decode_count <= (workload == '0) ? ctrl_pkg::timestamp_t'(1) : workload;
            end else if (decode_done) begin
                busy         <= 1'b0;
                result_valid <= wait_q;
            end else if (busy) begin
                decode_count <= decode_count - 1'b1;
            end
            if (result_valid && result_ready) begin
                result_valid <= 1'b0;
            end
        end
    end

    always_comb begin
        result_msg = '0;
        result_msg[`MSG_HEADER_MSB:`MSG_HEADER_LSB] = ctrl_pkg::HEADER_RESULT;
        result_msg[`MSG_STAMP_MSB:`MSG_STAMP_LSB]   = stamp;
        result_msg[`MSG_NODE_MSB:`MSG_NODE_LSB]     = NODE_ID;
    end

    // stamp captured at completion
    always_ff @(posedge clk) begin
        if (decode_done) begin
            result_data <= result_msg;
        end
    end

endmodule

// ==== src/root_controller.sv ====
`timescale 1ns/1ps
`include "ctrl_config.svh"

module root_controller #(
    parameter int NUM_CHILDREN = `CTRL_NUM_CHILDREN
) (
    input  logic                clk,
    input  logic                reset,

    input  ctrl_pkg::ctrl_msg_t data_from_cpu,
    input  logic                valid_from_cpu,
    output logic                ready_from_cpu,

    output ctrl_pkg::ctrl_msg_t data_to_cpu,
    output logic                valid_to_cpu,
    input  logic                ready_to_cpu,

    output ctrl_pkg::ctrl_msg_t data_to_fpgas,
    output logic                valid_to_fpgas,
    input  logic                ready_to_fpgas,

    input  ctrl_pkg::ctrl_msg_t data_from_fpgas,
    input  logic                valid_from_fpgas,
    output logic                ready_from_fpgas,

    input  logic                router_busy
);

    localparam ctrl_pkg::child_count_t ALL_RESULTS = ctrl_pkg::child_count_t'(NUM_CHILDREN);
    localparam ctrl_pkg::child_count_t LAST_RESULT =
        ctrl_pkg::child_count_t'(NUM_CHILDREN - 1);
    localparam ctrl_pkg::timestamp_t STAMP_MAX = '1;

    ctrl_pkg::root_stage_t  stage;
    logic                   report_all;
    ctrl_pkg::child_count_t result_count;
    ctrl_pkg::timestamp_t   stamp_q;
    logic                   busy_q;

    ctrl_pkg::node_id_t     cpu_dest;
    ctrl_pkg::msg_header_t  cpu_header;
    ctrl_pkg::timestamp_t   result_stamp;
    ctrl_pkg::timestamp_t   first_stamp;
    ctrl_pkg::timestamp_t   latency;
    ctrl_pkg::ctrl_msg_t    summary;
    logic                   cpu_accept;
    logic                   result_accept;
    logic                   all_received;

    assign cpu_dest     = data_from_cpu[`MSG_DEST_MSB:`MSG_DEST_LSB];
    assign cpu_header   = data_from_cpu[`MSG_HEADER_MSB:`MSG_HEADER_LSB];
    assign result_stamp = data_from_fpgas[`MSG_STAMP_MSB:`MSG_STAMP_LSB];
    assign cpu_accept   = valid_from_cpu && ready_from_cpu;
    assign all_received = (result_count == ALL_RESULTS);

    assign result_accept = valid_from_fpgas && ready_from_fpgas && !all_received &&
        (data_from_fpgas[`MSG_HEADER_MSB:`MSG_HEADER_LSB] == ctrl_pkg::HEADER_RESULT);

    // first stamp comes from the register, except on the very first result
    assign first_stamp = (result_count == '0) ? result_stamp : stamp_q;
    assign latency = (result_stamp > first_stamp) ? (result_stamp - first_stamp)
                                                  : (STAMP_MAX - first_stamp + result_stamp);

    // one register stage on the busy level from the leaves
    always_ff @(posedge clk) begin
        if (reset) begin
            busy_q <= 1'b0;
        end else begin
            busy_q <= router_busy;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            stage        <= ctrl_pkg::STAGE_IDLE;
            report_all   <= 1'b0;
            result_count <= '0;
        end else begin
            case (stage)
                ctrl_pkg::STAGE_IDLE: begin
                    result_count <= '0;
                    if (cpu_accept && cpu_dest == '0 &&
                        cpu_header == ctrl_pkg::HEADER_DECODE_BLOCK) begin
                        report_all <= data_from_cpu[`MSG_REPORT_ALL_BIT];
                        if (data_from_cpu[`MSG_WAIT_BIT]) begin
                            stage <= ctrl_pkg::STAGE_WAIT_TILL_NODE_RESULTS;
                        end
                    end
                end
                ctrl_pkg::STAGE_WAIT_TILL_NODE_RESULTS: begin
                    if (result_accept) begin
                        result_count <= result_count + 1'b1;
                    end else if (all_received && ready_to_cpu) begin
                        result_count <= '0;
                        stage        <= ctrl_pkg::STAGE_IDLE;
                    end
                end
                default: begin
                    stage <= ctrl_pkg::STAGE_IDLE;
                end
            endcase
        end
    end

    // first timestamp, overwritten by the latency on the last result
    always_ff @(posedge clk) begin
        if (result_accept) begin
            if (result_count == LAST_RESULT) begin
                stamp_q <= latency;
            end else if (result_count == '0) begin
                stamp_q <= result_stamp;
            end
        end
    end

    always_comb begin
        summary = '0;
        summary[`MSG_HEADER_MSB:`MSG_HEADER_LSB] = ctrl_pkg::HEADER_RESULT;
        summary[`MSG_SUMMARY_BIT] = 1'b1;
        summary[`MSG_VALUE_MSB:`MSG_VALUE_LSB] = stamp_q;
    end

    // cpu to leaves
    always_comb begin
        ready_from_cpu = 1'b0;
        valid_to_fpgas = 1'b0;
        data_to_fpgas  = data_from_cpu;
        if (stage == ctrl_pkg::STAGE_IDLE && !busy_q) begin
            ready_from_cpu = ready_to_fpgas;
            if (valid_from_cpu) begin
                if (cpu_dest == '0) begin
                    case (cpu_header)
                        ctrl_pkg::HEADER_INITIALIZE_DECODING,
                        ctrl_pkg::HEADER_DECODE_BLOCK,
                        ctrl_pkg::HEADER_RESET_CLOCK: begin
                            // root commands go out to every node
                            data_to_fpgas[`MSG_DEST_MSB:`MSG_DEST_LSB] = `CTRL_BROADCAST_DEST;
                            valid_to_fpgas = 1'b1;
                        end
                        ctrl_pkg::HEADER_SET_BOUNDARIES: begin
                            valid_to_fpgas = 1'b1;
                        end
                        default: begin
                            valid_to_fpgas = 1'b0;
                        end
                    endcase
                end else begin
                    valid_to_fpgas = 1'b1;
                end
            end
        end
    end

    // leaves to cpu
    always_comb begin
        data_to_cpu      = data_from_fpgas;
        valid_to_cpu     = 1'b0;
        ready_from_fpgas = 1'b0;
        if (stage == ctrl_pkg::STAGE_WAIT_TILL_NODE_RESULTS) begin
            if (all_received) begin
                data_to_cpu  = summary;
                valid_to_cpu = 1'b1;
            end else if (report_all) begin
                valid_to_cpu     = valid_from_fpgas;
                ready_from_fpgas = ready_to_cpu;
            end else begin
                // swallow results silently
                ready_from_fpgas = 1'b1;
            end
        end
    end

endmodule

// ==== verif/root_controller_chk.sv ====
`timescale 1ns/1ps
`include "ctrl_config.svh"

module root_controller_chk #(
    parameter int NUM_CHILDREN = `CTRL_NUM_CHILDREN
) (
    input logic                clk,
    input logic                reset,
    input ctrl_pkg::ctrl_msg_t data_from_cpu,
    input logic                valid_from_cpu,
    input logic                ready_from_cpu,
    input ctrl_pkg::ctrl_msg_t data_to_cpu,
    input logic                valid_to_cpu,
    input logic                ready_to_cpu,
    input ctrl_pkg::ctrl_msg_t data_to_fpgas,
    input logic                valid_to_fpgas,
    input ctrl_pkg::ctrl_msg_t data_from_fpgas,
    input logic                valid_from_fpgas,
    input logic                ready_from_fpgas
);

    localparam ctrl_pkg::timestamp_t STAMP_MAX = '1;

    int unsigned           error_count = 0;
    logic                  in_round;
    logic                  report_mode;
    int unsigned           seen;
    ctrl_pkg::timestamp_t  first_stamp;
    ctrl_pkg::timestamp_t  last_stamp;
    ctrl_pkg::timestamp_t  leaf_stamp;
    ctrl_pkg::timestamp_t  expect_latency;
    ctrl_pkg::ctrl_msg_t   expect_summary;
    ctrl_pkg::msg_header_t cpu_header;
    logic                  root_cmd;
    logic                  bcast_cmd;
    logic                  known_cmd;
    logic                  summary_due;

    assign cpu_header = data_from_cpu[`MSG_HEADER_MSB:`MSG_HEADER_LSB];
    assign root_cmd = valid_from_cpu && ready_from_cpu &&
        data_from_cpu[`MSG_DEST_MSB:`MSG_DEST_LSB] == '0;
    assign bcast_cmd = cpu_header == ctrl_pkg::HEADER_INITIALIZE_DECODING ||
        cpu_header == ctrl_pkg::HEADER_DECODE_BLOCK || cpu_header == ctrl_pkg::HEADER_RESET_CLOCK;
    assign known_cmd = bcast_cmd || cpu_header == ctrl_pkg::HEADER_SET_BOUNDARIES;
    assign leaf_stamp = data_from_fpgas[`MSG_STAMP_MSB:`MSG_STAMP_LSB];
    assign summary_due = in_round && seen == NUM_CHILDREN;

    // spread between first and last child stamps with wrap past the counter top
    assign expect_latency = (last_stamp > first_stamp) ? (last_stamp - first_stamp)
                                                       : (STAMP_MAX - first_stamp + last_stamp);
    assign expect_summary = {8'h00, ctrl_pkg::HEADER_RESULT, 16'h0000, 1'b1, 15'h0000,
                             expect_latency};

    // own view of the decode round
    always_ff @(posedge clk) begin
        if (reset) begin
            in_round    <= 1'b0;
            report_mode <= 1'b0;
            seen        <= 0;
        end else if (!in_round) begin
            if (root_cmd && cpu_header == ctrl_pkg::HEADER_DECODE_BLOCK &&
                data_from_cpu[`MSG_WAIT_BIT]) begin
                in_round    <= 1'b1;
                report_mode <= data_from_cpu[`MSG_REPORT_ALL_BIT];
                seen        <= 0;
            end
        end else if (summary_due) begin
            if (valid_to_cpu && ready_to_cpu) begin
                in_round <= 1'b0;
            end
        end else if (valid_from_fpgas && ready_from_fpgas) begin
            seen       <= seen + 1;
            last_stamp <= leaf_stamp;
            if (seen == 0) begin
                first_stamp <= leaf_stamp;
            end
        end
    end

    a_broadcast: assert property (@(posedge clk) disable iff (reset)
        root_cmd && bcast_cmd |-> valid_to_fpgas &&
        data_to_fpgas == {`CTRL_BROADCAST_DEST, data_from_cpu[`MSG_HEADER_MSB:0]})
        else begin
            error_count++;
            $error("Fail data_to_fpgas %h for root command %h", data_to_fpgas, data_from_cpu);
        end

    a_unchanged: assert property (@(posedge clk) disable iff (reset)
        valid_from_cpu && ready_from_cpu && !(root_cmd && bcast_cmd) && (!root_cmd || known_cmd)
        |-> valid_to_fpgas && data_to_fpgas == data_from_cpu)
        else begin
            error_count++;
            $error("Fail data_to_fpgas %h, sent %h", data_to_fpgas, data_from_cpu);
        end

    a_dropped: assert property (@(posedge clk) disable iff (reset)
        root_cmd && !known_cmd |-> !valid_to_fpgas)
        else begin
            error_count++;
            $error("Fail valid_to_fpgas %h for unknown header %h", valid_to_fpgas, cpu_header);
        end

    a_closed: assert property (@(posedge clk) disable iff (reset)
        in_round |-> !ready_from_cpu)
        else begin
            error_count++;
            $error("Fail ready_from_cpu %h inside a decode round", ready_from_cpu);
        end

    // each child result passes to the cpu with the cpu's own back-pressure
    a_forward: assert property (@(posedge clk) disable iff (reset)
        in_round && report_mode && seen < NUM_CHILDREN
        |-> valid_to_cpu == valid_from_fpgas && ready_from_fpgas == ready_to_cpu &&
            (!valid_from_fpgas || data_to_cpu == data_from_fpgas))
        else begin
            error_count++;
            $error("Fail data_to_cpu %h valid_to_cpu %h ready_from_fpgas %h, child result %h",
                   data_to_cpu, valid_to_cpu, ready_from_fpgas, data_from_fpgas);
        end

    a_hidden: assert property (@(posedge clk) disable iff (reset)
        in_round && !report_mode && seen < NUM_CHILDREN |-> !valid_to_cpu)
        else begin
            error_count++;
            $error("Fail valid_to_cpu %h before the summary", valid_to_cpu);
        end

    a_summary: assert property (@(posedge clk) disable iff (reset)
        summary_due |-> valid_to_cpu && data_to_cpu == expect_summary)
        else begin
            error_count++;
            $error("Fail data_to_cpu %h, expected %h", data_to_cpu, expect_summary);
        end

    a_held: assert property (@(posedge clk) disable iff (reset)
        summary_due && !ready_to_cpu |=> valid_to_cpu && $stable(data_to_cpu))
        else begin
            error_count++;
            $error("Fail data_to_cpu %h valid_to_cpu %h while stalled", data_to_cpu,
                   valid_to_cpu);
        end

endmodule

// one checker per root controller
bind root_controller root_controller_chk #(.NUM_CHILDREN(NUM_CHILDREN)) chk_i (.*);

// ==== verif/tb_decoder_cluster.sv ====
`timescale 1ns/1ps
`include "ctrl_config.svh"

module tb_decoder_cluster;

    localparam int NUM_ROUNDS = 6;
    localparam int MAX_WORK = 20;
    // setup and the fixed rounds add four more
    localparam int WATCHDOG_CYCLES = (NUM_ROUNDS + 4) * (MAX_WORK + 40);

    logic                clk = 1'b0;
    logic                reset = 1'b1;
    ctrl_pkg::ctrl_msg_t data_from_cpu = '0;
    logic                valid_from_cpu = 1'b0;
    logic                ready_from_cpu;
    ctrl_pkg::ctrl_msg_t data_to_cpu;
    logic                valid_to_cpu;
    logic                ready_to_cpu = 1'b0;
    logic                hold_ready = 1'b0;

    decoder_cluster_top dut_i (
        .clk           (clk),
        .reset         (reset),
        .data_from_cpu (data_from_cpu),
        .valid_from_cpu(valid_from_cpu),
        .ready_from_cpu(ready_from_cpu),
        .data_to_cpu   (data_to_cpu),
        .valid_to_cpu  (valid_to_cpu),
        .ready_to_cpu  (ready_to_cpu)
    );

    always #5 clk = ~clk;

    // cpu sink with random gaps that stays closed while a summary is held
    always @(posedge clk) begin
        if (reset || hold_ready) begin
            ready_to_cpu <= 1'b0;
        end else begin
            ready_to_cpu <= ($urandom_range(3) != 0);
        end
    end

    function automatic ctrl_pkg::ctrl_msg_t make_msg(
        input ctrl_pkg::node_id_t    dest,
        input ctrl_pkg::msg_header_t header,
        input logic [47:0]           body
    );
        return {dest, header, body};
    endfunction

    function automatic logic [47:0] random_body();
        return 48'({$urandom, $urandom});
    endfunction

    // ready only moves on the rising edge, so it is settled at the falling one
    task automatic send_msg(input ctrl_pkg::ctrl_msg_t msg);
        data_from_cpu  <= msg;
        valid_from_cpu <= 1'b1;
        do begin
            @(negedge clk);
        end while (!ready_from_cpu);
        @(posedge clk);
        valid_from_cpu <= 1'b0;
    endtask

    task automatic set_workloads();
        logic [47:0] body;
        for (int n = 1; n <= `CTRL_NUM_CHILDREN; n++) begin
            body = random_body();
            body[`MSG_VALUE_MSB:`MSG_VALUE_LSB] = 16'($urandom_range(MAX_WORK, 1));
            send_msg(make_msg(ctrl_pkg::node_id_t'(n), ctrl_pkg::HEADER_SET_BOUNDARIES, body));
        end
    endtask

    task automatic decode_round(input logic report_all, input logic hold_summary);
        logic [47:0] body;
        body = random_body();
        body[`MSG_REPORT_ALL_BIT] = report_all;
        body[`MSG_WAIT_BIT] = 1'b1;
        if (hold_summary) begin
            hold_ready <= 1'b1;
        end
        send_msg(make_msg(8'h00, ctrl_pkg::HEADER_DECODE_BLOCK, body));
        if (hold_summary) begin
            // without report-all the first thing the cpu sees is the summary
            do begin
                @(negedge clk);
            end while (!valid_to_cpu);
            repeat (5) @(posedge clk);
            hold_ready <= 1'b0;
        end
    endtask

    initial begin
        logic [47:0] body;
        void'($urandom(32'hd95));
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        send_msg(make_msg(8'h00, ctrl_pkg::HEADER_RESET_CLOCK, random_body()));
        send_msg(make_msg(8'h00, ctrl_pkg::HEADER_INITIALIZE_DECODING, random_body()));
        // root-addressed boundaries pass through but no leaf takes them
        send_msg(make_msg(8'h00, ctrl_pkg::HEADER_SET_BOUNDARIES, random_body()));
        send_msg(make_msg(8'h00, 8'h09, random_body()));
        // equal default workloads give equal stamps and hit the wrap branch
        decode_round(1'b1, 1'b0);
        for (int r = 0; r < NUM_ROUNDS; r++) begin
            set_workloads();
            decode_round(r[0], r == 2);
        end
        // decode with no wait bit makes the leaves busy without a report
        body = random_body();
        body[`MSG_WAIT_BIT] = 1'b0;
        send_msg(make_msg(8'h00, ctrl_pkg::HEADER_DECODE_BLOCK, body));
        decode_round(1'b1, 1'b0);
        do begin
            @(negedge clk);
        end while (!ready_from_cpu);
        repeat (2) @(posedge clk);
        @(negedge clk);
        if (dut_i.root_i.chk_i.error_count == 0) begin
            $display("Testbench passed");
            $finish;
        end else begin
            $display("Testbench failed");
            $fatal(1, "root controller checks reported errors");
        end
    end

    // stop at the first assertion failure
    always @(negedge clk) begin
        if (dut_i.root_i.chk_i.error_count != 0) begin
            $display("Testbench failed");
            $fatal(1, "a root controller check failed");
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * 10);
        $display("Testbench failed");
        $fatal(1, "timeout, the cluster stopped responding");
    end

endmodule

// ==== verilog.f ====
+incdir+include
src/ctrl_pkg.sv
src/root_controller.sv
src/child_fanout.sv
src/leaf_node.sv
src/decoder_cluster_top.sv
verif/root_controller_chk.sv
verif/tb_decoder_cluster.sv
